// ==== hdl/fetch_pkg.sv ====
/*
 * shared definitions for the instruction fetch front end
 * widths, reset PC, predictor geometry, exception causes and the
 * fetch packet handed from the memory stage to decode
 * referenced by scoped names from every design and test file
 */
`default_nettype none

package fetch_pkg;

    // address and instruction width
    localparam int XLEN = 32;

    // first fetch address after reset
    localparam logic [XLEN-1:0] RESET_PC = 32'h0000_1000;

    // sequential step, no compressed instructions
    localparam logic [XLEN-1:0] INSTR_BYTES = 32'd4;

    // direct-mapped predictor, index from pc[5:2]
    localparam int BP_ENTRIES = 16;
    localparam int BP_IDX_W   = 4;
    // tag is everything above the index
    localparam int BP_TAG_W   = XLEN - BP_IDX_W - 2;

    // 2-bit counter values
    localparam logic [1:0] BP_CNT_INIT  = 2'b01;
    localparam logic [1:0] BP_CNT_ALLOC = 2'b10;

    // exception causes, RISC-V mcause encoding
    localparam int CAUSE_W = 4;
    localparam logic [CAUSE_W-1:0] XCPT_INSTR_MISALIGNED   = 4'd0;
    localparam logic [CAUSE_W-1:0] XCPT_INSTR_ACCESS_FAULT = 4'd1;

    // packet held in the memory stage output register
    typedef struct packed {
        logic [XLEN-1:0]    pc;
        logic [XLEN-1:0]    instr;
        logic               xcpt_valid;
        logic [CAUSE_W-1:0] xcpt_cause;
        // prediction made in the pc stage, checked later by execution
        logic               pred_taken;
        logic [XLEN-1:0]    pred_target;
    } fetch_pkt_t;

endpackage

`default_nettype wire

// ==== hdl/fetch_req_if.sv ====
/*
 * fetch request channel from the pc stage to the memory stage
 * valid/ready handshake, transfer on an edge with both high
 * fields hold while valid is high and ready is low
 */
`timescale 1ns/100ps
`default_nettype none

interface fetch_req_if;

    logic                       valid;
    logic                       ready;
    logic [fetch_pkg::XLEN-1:0] pc;
    // low pc bits set, no bus cycle for this one
    logic                       misaligned;
    logic                       pred_taken;
    logic [fetch_pkg::XLEN-1:0] pred_target;

    modport pc_stage (
        output valid, pc, misaligned, pred_taken, pred_target,
        input  ready
    );

    modport mem_stage (
        input  valid, pc, misaligned, pred_taken, pred_target,
        output ready
    );

endinterface

`default_nettype wire

// ==== hdl/branch_predictor.sv ====
/*
 * direct-mapped branch predictor with 2-bit saturating counters
 * lookup is combinational on the fetch pc
 * execution writes outcomes through the update port, visible next cycle
 */
`timescale 1ns/100ps
`default_nettype none

module branch_predictor (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic [fetch_pkg::XLEN-1:0] lookup_pc_i,
    input  logic                       upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_pc_i,
    input  logic                       upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] upd_target_i,
    output logic                       hit_o,
    output logic                       taken_o,
    output logic [fetch_pkg::XLEN-1:0] target_o
);

    // per-entry state
    logic                           valid_q  [fetch_pkg::BP_ENTRIES];
    logic [1:0]                     cnt_q    [fetch_pkg::BP_ENTRIES];
    logic [fetch_pkg::BP_TAG_W-1:0] tag_q    [fetch_pkg::BP_ENTRIES];
    logic [fetch_pkg::XLEN-1:0]     target_q [fetch_pkg::BP_ENTRIES];

    logic [fetch_pkg::BP_IDX_W-1:0] lk_idx;
    logic [fetch_pkg::BP_TAG_W-1:0] lk_tag;
    logic [fetch_pkg::BP_IDX_W-1:0] up_idx;
    logic [fetch_pkg::BP_TAG_W-1:0] up_tag;
    logic                           up_hit;

    // split pc into index and tag, word offset dropped
    assign lk_idx = lookup_pc_i[fetch_pkg::BP_IDX_W+1:2];
    assign lk_tag = lookup_pc_i[fetch_pkg::XLEN-1:fetch_pkg::BP_IDX_W+2];
    assign up_idx = upd_pc_i[fetch_pkg::BP_IDX_W+1:2];
    assign up_tag = upd_pc_i[fetch_pkg::XLEN-1:fetch_pkg::BP_IDX_W+2];

    // lookup
    assign hit_o    = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    // counter msb set means 2 or 3
    assign taken_o  = cnt_q[lk_idx][1];
    assign target_o = target_q[lk_idx];

    // update side sees the same table
    assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

    // valid bits and counters
    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++) begin
                valid_q[i] <= 1'b0;
                cnt_q[i]   <= fetch_pkg::BP_CNT_INIT;
            end
        end else if (upd_valid_i) begin
            if (up_hit) begin
                // step toward the outcome, saturate at 0 and 3
                if (upd_taken_i && cnt_q[up_idx] != 2'b11) begin
                    cnt_q[up_idx] <= cnt_q[up_idx] + 2'b01;
                end else if (!upd_taken_i && cnt_q[up_idx] != 2'b00) begin
                    cnt_q[up_idx] <= cnt_q[up_idx] - 2'b01;
                end
            end else if (upd_taken_i) begin
                // allocate on a taken miss, weakly taken
                valid_q[up_idx] <= 1'b1;
                cnt_q[up_idx]   <= fetch_pkg::BP_CNT_ALLOC;
            end
        end
    end

    // tags and targets, only meaningful once valid
    always_ff @(posedge clk_i) begin
        if (upd_valid_i && upd_taken_i) begin
            // refresh target on a taken hit, fill on a taken miss
            tag_q[up_idx]    <= up_tag;
            target_q[up_idx] <= upd_target_i;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pc_stage.sv ====
/*
 * pc stage of the fetch front end
 * holds the fetch address, presents it as a request to the memory stage
 * next pc by priority: redirect, taken prediction, pc+4
 */
`timescale 1ns/100ps
`default_nettype none

module pc_stage (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] redirect_pc_i,
    input  logic                       bp_upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] bp_upd_pc_i,
    input  logic                       bp_upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0] bp_upd_target_i,
    fetch_req_if.pc_stage              req_o
);

    logic [fetch_pkg::XLEN-1:0] pc_q;
    logic [fetch_pkg::XLEN-1:0] pc_d;
    logic                       valid_q;

    // predictor outputs for the current pc
    logic                       bp_hit;
    logic                       bp_taken;
    logic [fetch_pkg::XLEN-1:0] bp_target;
    logic                       pred_taken;
    logic                       req_fire;

    branch_predictor u_bp (
        .clk_i        (clk_i),
        .rstn_i       (rstn_i),
        .lookup_pc_i  (pc_q),
        .upd_valid_i  (bp_upd_valid_i),
        .upd_pc_i     (bp_upd_pc_i),
        .upd_taken_i  (bp_upd_taken_i),
        .upd_target_i (bp_upd_target_i),
        .hit_o        (bp_hit),
        .taken_o      (bp_taken),
        .target_o     (bp_target)
    );

    // only a hit that predicts taken redirects fetch
    assign pred_taken = bp_hit && bp_taken;

    assign req_fire = req_o.valid && req_o.ready;

    always_comb begin
        pc_d = pc_q;
        if (redirect_valid_i) begin
            // flush wins, independent of ready
            pc_d = redirect_pc_i;
        end else if (req_fire) begin
            if (pred_taken) begin
                pc_d = bp_target;
            end else begin
                pc_d = pc_q + fetch_pkg::INSTR_BYTES;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            pc_q    <= fetch_pkg::RESET_PC;
            valid_q <= 1'b0;
        end else begin
            pc_q    <= pc_d;
            // a pc is always on offer once out of reset
            valid_q <= 1'b1;
        end
    end

    // request fields
    assign req_o.valid       = valid_q;
    assign req_o.pc          = pc_q;
    // either low bit set is a misaligned fetch
    assign req_o.misaligned  = |pc_q[1:0];
    // travels with the packet so execution can check it
    assign req_o.pred_taken  = pred_taken;
    assign req_o.pred_target = bp_target;

endmodule

`default_nettype wire

// ==== hdl/imem_wb_stage.sv ====
/*
 * memory stage of the fetch front end
 * one Wishbone classic read per aligned request, misaligned ones skip the bus
 * result goes into a held output register, consumed on valid and ready
 * a redirect empties the register and drops the result of an open cycle
 */
`timescale 1ns/100ps
`default_nettype none

module imem_wb_stage (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       redirect_valid_i,
    fetch_req_if.mem_stage             req_i,
    output logic                       wb_cyc_o,
    output logic                       wb_stb_o,
    output logic [fetch_pkg::XLEN-1:0] wb_adr_o,
    input  logic [fetch_pkg::XLEN-1:0] wb_dat_i,
    input  logic                       wb_ack_i,
    input  logic                       wb_err_i,
    output logic                       fetch_valid_o,
    input  logic                       fetch_ready_i,
    output fetch_pkg::fetch_pkt_t      fetch_pkt_o
);

    // control state
    logic busy_q;
    logic drop_q;
    logic out_valid_q;

    // request held while the bus cycle is open
    logic [fetch_pkg::XLEN-1:0] pend_pc_q;
    logic                       pend_pred_taken_q;
    logic [fetch_pkg::XLEN-1:0] pend_pred_target_q;

    fetch_pkg::fetch_pkt_t pkt_q;
    fetch_pkg::fetch_pkt_t pkt_d;

    logic accept;
    logic bus_done;
    logic load_xcpt;
    logic load_bus;

    // no new request while the bus is busy or the output is stuck
    assign req_i.ready = !busy_q && (!out_valid_q || fetch_ready_i);

    // request taken in a redirect cycle is stale
    assign accept    = req_i.valid && req_i.ready && !redirect_valid_i;
    assign bus_done  = busy_q && (wb_ack_i || wb_err_i);
    assign load_xcpt = accept && req_i.misaligned;
    assign load_bus  = bus_done && !drop_q && !redirect_valid_i;

    // packet to register
    always_comb begin
        pkt_d = pkt_q;
        if (load_xcpt) begin
            pkt_d.pc          = req_i.pc;
            pkt_d.instr       = '0;
            pkt_d.xcpt_valid  = 1'b1;
            pkt_d.xcpt_cause  = fetch_pkg::XCPT_INSTR_MISALIGNED;
            pkt_d.pred_taken  = req_i.pred_taken;
            pkt_d.pred_target = req_i.pred_target;
        end else if (load_bus) begin
            pkt_d.pc          = pend_pc_q;
            pkt_d.pred_taken  = pend_pred_taken_q;
            pkt_d.pred_target = pend_pred_target_q;
            // err beats ack
            if (wb_err_i) begin
                pkt_d.instr      = '0;
                pkt_d.xcpt_valid = 1'b1;
                pkt_d.xcpt_cause = fetch_pkg::XCPT_INSTR_ACCESS_FAULT;
            end else begin
                pkt_d.instr      = wb_dat_i;
                pkt_d.xcpt_valid = 1'b0;
                pkt_d.xcpt_cause = '0;
            end
        end
    end

    always_ff @(posedge clk_i, negedge rstn_i) begin
        if (!rstn_i) begin
            busy_q      <= 1'b0;
            drop_q      <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            // bus cycle open from accept to ack or err
            if (accept && !req_i.misaligned) begin
                busy_q <= 1'b1;
            end else if (bus_done) begin
                busy_q <= 1'b0;
            end
            // remember a flush that hit an open cycle
            if (bus_done) begin
                drop_q <= 1'b0;
            end else if (redirect_valid_i && busy_q) begin
                drop_q <= 1'b1;
            end
            if (redirect_valid_i) begin
                out_valid_q <= 1'b0;
            end else if (load_xcpt || load_bus) begin
                out_valid_q <= 1'b1;
            end else if (fetch_ready_i) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // payload registers
    always_ff @(posedge clk_i) begin
        if (accept) begin
            pend_pc_q          <= req_i.pc;
            pend_pred_taken_q  <= req_i.pred_taken;
            pend_pred_target_q <= req_i.pred_target;
        end
        pkt_q <= pkt_d;
    end

    assign wb_cyc_o = busy_q;
    assign wb_stb_o = busy_q;
    assign wb_adr_o = pend_pc_q;

    assign fetch_valid_o = out_valid_q;
    assign fetch_pkt_o   = pkt_q;

endmodule

`default_nettype wire

// ==== hdl/fetch_top.sv ====
/*
 * top level of the instruction fetch front end
 * pc stage and Wishbone memory stage joined by the request channel
 * fetch packet broken out to plain ports for decode
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_top (
    input  logic                          clk_i,
    input  logic                          rstn_i,
    // redirect from execution or commit
    input  logic                          redirect_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]    redirect_pc_i,
    // predictor training
    input  logic                          bp_upd_valid_i,
    input  logic [fetch_pkg::XLEN-1:0]    bp_upd_pc_i,
    input  logic                          bp_upd_taken_i,
    input  logic [fetch_pkg::XLEN-1:0]    bp_upd_target_i,
    // Wishbone read master
    output logic                          wb_cyc_o,
    output logic                          wb_stb_o,
    output logic [fetch_pkg::XLEN-1:0]    wb_adr_o,
    input  logic [fetch_pkg::XLEN-1:0]    wb_dat_i,
    input  logic                          wb_ack_i,
    input  logic                          wb_err_i,
    // fetch packet to decode
    output logic                          fetch_valid_o,
    input  logic                          fetch_ready_i,
    output logic [fetch_pkg::XLEN-1:0]    fetch_pc_o,
    output logic [fetch_pkg::XLEN-1:0]    fetch_instr_o,
    output logic                          fetch_xcpt_valid_o,
    output logic [fetch_pkg::CAUSE_W-1:0] fetch_xcpt_cause_o,
    output logic                          fetch_pred_taken_o,
    output logic [fetch_pkg::XLEN-1:0]    fetch_pred_target_o
);

    fetch_req_if req_if ();

    fetch_pkg::fetch_pkt_t pkt;

    pc_stage u_pc_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .bp_upd_valid_i   (bp_upd_valid_i),
        .bp_upd_pc_i      (bp_upd_pc_i),
        .bp_upd_taken_i   (bp_upd_taken_i),
        .bp_upd_target_i  (bp_upd_target_i),
        .req_o            (req_if.pc_stage)
    );

    imem_wb_stage u_imem_wb_stage (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .redirect_valid_i (redirect_valid_i),
        .req_i            (req_if.mem_stage),
        .wb_cyc_o         (wb_cyc_o),
        .wb_stb_o         (wb_stb_o),
        .wb_adr_o         (wb_adr_o),
        .wb_dat_i         (wb_dat_i),
        .wb_ack_i         (wb_ack_i),
        .wb_err_i         (wb_err_i),
        .fetch_valid_o    (fetch_valid_o),
        .fetch_ready_i    (fetch_ready_i),
        .fetch_pkt_o      (pkt)
    );

    // packet fields out to plain ports
    assign fetch_pc_o          = pkt.pc;
    assign fetch_instr_o       = pkt.instr;
    assign fetch_xcpt_valid_o  = pkt.xcpt_valid;
    assign fetch_xcpt_cause_o  = pkt.xcpt_cause;
    assign fetch_pred_taken_o  = pkt.pred_taken;
    assign fetch_pred_target_o = pkt.pred_target;

endmodule

`default_nettype wire

// ==== test/clk_rst_gen.sv ====
/*
 * testbench clock and reset source
 * 8 ns clock, active-low reset released after 3 cycles on a falling edge
 */
`timescale 1ns/100ps
`default_nettype none

module clk_rst_gen (
    output logic clk_o,
    output logic rstn_o
);

    localparam int HALF_NS    = 4;
    localparam int RST_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_NS clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        // release away from the sampling edge
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== test/fetch_asserts.sv ====
/*
 * concurrent checks on the fetch front end ports
 * Wishbone classic request rules and packet hold under back-pressure
 * attached to fetch_top with bind from the testbench
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_asserts (
    input logic                          clk_i,
    input logic                          rstn_i,
    input logic                          redirect_valid_i,
    input logic                          wb_cyc_o,
    input logic                          wb_stb_o,
    input logic [fetch_pkg::XLEN-1:0]    wb_adr_o,
    input logic                          wb_ack_i,
    input logic                          wb_err_i,
    input logic                          fetch_valid_o,
    input logic                          fetch_ready_i,
    input logic [fetch_pkg::XLEN-1:0]    fetch_pc_o,
    input logic [fetch_pkg::XLEN-1:0]    fetch_instr_o,
    input logic                          fetch_xcpt_valid_o,
    input logic [fetch_pkg::CAUSE_W-1:0] fetch_xcpt_cause_o,
    input logic                          fetch_pred_taken_o,
    input logic [fetch_pkg::XLEN-1:0]    fetch_pred_target_o
);

    // cyc and stb move as one
    assert property (@(posedge clk_i) disable iff (!rstn_i) wb_cyc_o == wb_stb_o)
        else $error("wb_cyc_o and wb_stb_o differ");

    // request held with a stable address until ack or err
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_cyc_o && !wb_ack_i && !wb_err_i |=> wb_cyc_o && wb_stb_o && $stable(wb_adr_o))
        else $error("bus request dropped or address moved before ack");

    // cycle ends at the ack or err edge
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        wb_cyc_o && (wb_ack_i || wb_err_i) |=> !wb_cyc_o)
        else $error("bus cycle still open after ack or err");

    // held packet frozen until consumed or flushed
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        fetch_valid_o && !fetch_ready_i && !redirect_valid_i |=>
            fetch_valid_o && $stable(fetch_pc_o) && $stable(fetch_instr_o)
            && $stable(fetch_xcpt_valid_o) && $stable(fetch_xcpt_cause_o)
            && $stable(fetch_pred_taken_o)
            && (!fetch_pred_taken_o || $stable(fetch_pred_target_o)))
        else $error("held fetch packet changed under back-pressure");

endmodule

`default_nettype wire

// ==== test/fetch_tb.sv ====
/*
 * testbench for the instruction fetch front end
 * Wishbone memory model with random wait states, directed redirects and
 * predictor training, then random back-pressure from decode
 * each consumed packet is compared with a reference model of the fetch path
 */
`timescale 1ns/100ps
`default_nettype none

module fetch_tb;

    typedef logic [fetch_pkg::XLEN-1:0] word_t;

    localparam int    CLK_NS   = 8;
    localparam int    EXP_PKTS = 66;
    localparam word_t MEM_KEY  = 32'h5a5a_0f0f;
    localparam word_t ERR_BASE = 32'h8000_0000;
    localparam word_t BR_PC    = 32'h0000_4010;
    localparam word_t BR_TGT   = 32'h0000_5020;

    logic                          clk;
    logic                          rstn;
    logic                          redirect_valid;
    word_t                         redirect_pc;
    logic                          bp_upd_valid;
    word_t                         bp_upd_pc;
    logic                          bp_upd_taken;
    word_t                         bp_upd_target;
    logic                          wb_cyc;
    logic                          wb_stb;
    word_t                         wb_adr;
    word_t                         wb_dat;
    logic                          wb_ack;
    logic                          wb_err;
    logic                          fetch_valid;
    logic                          fetch_ready;
    word_t                         fetch_pc;
    word_t                         fetch_instr;
    logic                          fetch_xcpt_valid;
    logic [fetch_pkg::CAUSE_W-1:0] fetch_xcpt_cause;
    logic                          fetch_pred_taken;
    word_t                         fetch_pred_target;

    // reference copy of the predictor table, full pc kept for the tag
    logic       m_valid  [fetch_pkg::BP_ENTRIES];
    logic [1:0] m_cnt    [fetch_pkg::BP_ENTRIES];
    word_t      m_pc     [fetch_pkg::BP_ENTRIES];
    word_t      m_target [fetch_pkg::BP_ENTRIES];

    integer      seed;
    logic [31:0] rnd;
    logic        bus_open;
    logic [1:0]  wait_left;
    logic        random_ready;
    word_t       exp_pc;
    int          consumed;
    int          checks;
    int          value_errs;
    int          other_errs;

    clk_rst_gen u_clk_rst_gen (
        .clk_o  (clk),
        .rstn_o (rstn)
    );

    fetch_top UUT (
        .clk_i               (clk),
        .rstn_i              (rstn),
        .redirect_valid_i    (redirect_valid),
        .redirect_pc_i       (redirect_pc),
        .bp_upd_valid_i      (bp_upd_valid),
        .bp_upd_pc_i         (bp_upd_pc),
        .bp_upd_taken_i      (bp_upd_taken),
        .bp_upd_target_i     (bp_upd_target),
        .wb_cyc_o            (wb_cyc),
        .wb_stb_o            (wb_stb),
        .wb_adr_o            (wb_adr),
        .wb_dat_i            (wb_dat),
        .wb_ack_i            (wb_ack),
        .wb_err_i            (wb_err),
        .fetch_valid_o       (fetch_valid),
        .fetch_ready_i       (fetch_ready),
        .fetch_pc_o          (fetch_pc),
        .fetch_instr_o       (fetch_instr),
        .fetch_xcpt_valid_o  (fetch_xcpt_valid),
        .fetch_xcpt_cause_o  (fetch_xcpt_cause),
        .fetch_pred_taken_o  (fetch_pred_taken),
        .fetch_pred_target_o (fetch_pred_target)
    );

    bind fetch_top fetch_asserts u_fetch_asserts (
        .clk_i               (clk_i),
        .rstn_i              (rstn_i),
        .redirect_valid_i    (redirect_valid_i),
        .wb_cyc_o            (wb_cyc_o),
        .wb_stb_o            (wb_stb_o),
        .wb_adr_o            (wb_adr_o),
        .wb_ack_i            (wb_ack_i),
        .wb_err_i            (wb_err_i),
        .fetch_valid_o       (fetch_valid_o),
        .fetch_ready_i       (fetch_ready_i),
        .fetch_pc_o          (fetch_pc_o),
        .fetch_instr_o       (fetch_instr_o),
        .fetch_xcpt_valid_o  (fetch_xcpt_valid_o),
        .fetch_xcpt_cause_o  (fetch_xcpt_cause_o),
        .fetch_pred_taken_o  (fetch_pred_taken_o),
        .fetch_pred_target_o (fetch_pred_target_o)
    );

    // memory contents, every address bit matters
    function automatic word_t mem_word(input word_t addr);
        return addr ^ MEM_KEY;
    endfunction

    // index from pc[5:2], tag is the rest above it
    function automatic logic [fetch_pkg::BP_IDX_W-1:0] bp_index(input word_t pc);
        return pc[fetch_pkg::BP_IDX_W+1:2];
    endfunction

    function automatic logic model_hit(input word_t pc);
        logic [fetch_pkg::BP_IDX_W-1:0] idx;
        idx = bp_index(pc);
        return m_valid[idx] && (m_pc[idx][fetch_pkg::XLEN-1:fetch_pkg::BP_IDX_W+2]
                                == pc[fetch_pkg::XLEN-1:fetch_pkg::BP_IDX_W+2]);
    endfunction

    function automatic logic model_taken(input word_t pc);
        return model_hit(pc) && (m_cnt[bp_index(pc)] >= 2'd2);
    endfunction

    // packet the front end should hand out for a fetch at pc
    function automatic fetch_pkg::fetch_pkt_t expected_pkt(input word_t pc);
        fetch_pkg::fetch_pkt_t p;
        p    = '0;
        p.pc = pc;
        if (pc[1:0] != 2'b00) begin
            p.xcpt_valid = 1'b1;
            p.xcpt_cause = fetch_pkg::XCPT_INSTR_MISALIGNED;
        end else if (pc >= ERR_BASE) begin
            p.xcpt_valid = 1'b1;
            p.xcpt_cause = fetch_pkg::XCPT_INSTR_ACCESS_FAULT;
        end else begin
            p.instr = mem_word(pc);
        end
        p.pred_taken = model_taken(pc);
        if (p.pred_taken) begin
            p.pred_target = m_target[bp_index(pc)];
        end
        return p;
    endfunction

    function automatic word_t next_pc(input word_t pc);
        return model_taken(pc) ? m_target[bp_index(pc)] : pc + 32'd4;
    endfunction

    // 2-bit counter training, allocate only on a taken miss
    task automatic train_model(input word_t pc, input logic taken, input word_t target);
        logic [fetch_pkg::BP_IDX_W-1:0] idx;
        idx = bp_index(pc);
        if (model_hit(pc)) begin
            if (taken && m_cnt[idx] != 2'd3) begin
                m_cnt[idx] = m_cnt[idx] + 2'd1;
            end else if (!taken && m_cnt[idx] != 2'd0) begin
                m_cnt[idx] = m_cnt[idx] - 2'd1;
            end
            if (taken) begin
                m_target[idx] = target;
            end
        end else if (taken) begin
            m_valid[idx]  = 1'b1;
            m_cnt[idx]    = 2'b10;
            m_pc[idx]     = pc;
            m_target[idx] = target;
        end
    endtask

    task automatic compare_field(input string name, input word_t got, input word_t exp);
        checks = checks + 1;
        assert (got === exp) else begin
            value_errs = value_errs + 1;
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_pkt(input fetch_pkg::fetch_pkt_t exp);
        compare_field("fetch_pc_o", fetch_pc, exp.pc);
        compare_field("fetch_xcpt_valid_o", word_t'(fetch_xcpt_valid),
                      word_t'(exp.xcpt_valid));
        // instr only defined without an exception
        if (exp.xcpt_valid) begin
            compare_field("fetch_xcpt_cause_o", word_t'(fetch_xcpt_cause),
                          word_t'(exp.xcpt_cause));
        end else begin
            compare_field("fetch_instr_o", fetch_instr, exp.instr);
        end
        compare_field("fetch_pred_taken_o", word_t'(fetch_pred_taken),
                      word_t'(exp.pred_taken));
        if (exp.pred_taken) begin
            compare_field("fetch_pred_target_o", fetch_pred_target, exp.pred_target);
        end
    endtask

    // checker, inputs settled since the falling edge
    initial begin
        exp_pc     = fetch_pkg::RESET_PC;
        consumed   = 0;
        checks     = 0;
        value_errs = 0;
        for (int i = 0; i < fetch_pkg::BP_ENTRIES; i++) begin
            m_valid[i] = 1'b0;
            m_cnt[i]   = 2'b01;
        end
        forever begin
            @(posedge clk);
            if (rstn) begin
                if (redirect_valid) begin
                    // packet flushed in this cycle is not consumed
                    exp_pc = redirect_pc;
                end else if (fetch_valid && fetch_ready) begin
                    compare_pkt(expected_pkt(exp_pc));
                    exp_pc   = next_pc(exp_pc);
                    consumed = consumed + 1;
                end
                // table change seen by lookups from the next cycle
                if (bp_upd_valid) begin
                    train_model(bp_upd_pc, bp_upd_taken, bp_upd_target);
                end
            end
        end
    end

    // decode ready and Wishbone slave, both on the falling edge
    initial begin
        seed        = 32'h3566_f109;
        wb_dat      = '0;
        wb_ack      = 1'b0;
        wb_err      = 1'b0;
        fetch_ready = 1'b1;
        bus_open    = 1'b0;
        wait_left   = 2'd0;
        other_errs  = 0;
        forever begin
            @(negedge clk);
            if (random_ready) begin
                rnd         = $random(seed);
                fetch_ready = rnd[0];
            end else begin
                fetch_ready = 1'b1;
            end
            if (wb_ack || wb_err) begin
                // master drops cyc on the edge that saw the response
                wb_ack = 1'b0;
                wb_err = 1'b0;
            end else if (wb_cyc && wb_stb) begin
                if (!bus_open) begin
                    bus_open  = 1'b1;
                    rnd       = $random(seed);
                    wait_left = rnd[1:0];
                    assert (wb_adr[1:0] == 2'b00) else begin
                        other_errs = other_errs + 1;
                        $display("bus cycle opened for misaligned address %h", wb_adr);
                    end
                end
                if (wait_left == 2'd0) begin
                    bus_open = 1'b0;
                    wb_dat   = mem_word(wb_adr);
                    if (wb_adr >= ERR_BASE) begin
                        wb_err = 1'b1;
                    end else begin
                        wb_ack = 1'b1;
                    end
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    task automatic wait_packets(input int n);
        int target;
        target = consumed + n;
        while (consumed < target) begin
            @(negedge clk);
        end
    endtask

    task automatic redirect_to(input word_t pc);
        redirect_valid = 1'b1;
        redirect_pc    = pc;
        @(negedge clk);
        redirect_valid = 1'b0;
    endtask

    // update and flush together, so no packet carries a stale prediction
    task automatic train_and_restart(input word_t pc, input logic taken,
                                     input word_t target, input word_t restart);
        bp_upd_valid  = 1'b1;
        bp_upd_pc     = pc;
        bp_upd_taken  = taken;
        bp_upd_target = target;
        redirect_to(restart);
        bp_upd_valid  = 1'b0;
    endtask

    initial begin
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        bp_upd_valid   = 1'b0;
        bp_upd_pc      = '0;
        bp_upd_taken   = 1'b0;
        bp_upd_target  = '0;
        random_ready   = 1'b0;
        @(posedge rstn);
        // sequential fetch from the reset pc
        wait_packets(8);
        redirect_to(32'h0000_2000);
        wait_packets(6);
        // misaligned target, no bus cycle expected
        redirect_to(32'h0000_3001);
        wait_packets(1);
        // bus error region
        redirect_to(32'h8000_0100);
        wait_packets(3);
        // taken branch at BR_PC, then two not-taken outcomes
        train_and_restart(BR_PC, 1'b1, BR_TGT, BR_PC - 32'd8);
        wait_packets(4);
        train_and_restart(BR_PC, 1'b0, '0, BR_PC - 32'd8);
        train_and_restart(BR_PC, 1'b0, '0, BR_PC - 32'd8);
        wait_packets(4);
        // random back-pressure, switched between edges
        @(posedge clk);
        random_ready = 1'b1;
        @(negedge clk);
        redirect_to(32'h0000_6000);
        wait_packets(40);
        repeat (4) @(negedge clk);
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // generous bound of 40 cycles per expected packet
    initial begin
        #(EXP_PKTS * 40 * CLK_NS);
        $display("watchdog expired with %0d of %0d packets consumed", consumed, EXP_PKTS);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
hdl/fetch_pkg.sv
hdl/fetch_req_if.sv
hdl/branch_predictor.sv
hdl/pc_stage.sv
hdl/imem_wb_stage.sv
hdl/fetch_top.sv
test/clk_rst_gen.sv
test/fetch_asserts.sv
test/fetch_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
TOP       ?= fetch_tb
FLIST     ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
